// ==== bench/cache_model.svh ====
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// test window of 64 lines, four words each
typedef logic [5:0] lidx_t;  // line index inside the window

cache_bus_pkg::line_t mem  [64];  // lower memory, follows every observed write-back
cache_bus_pkg::line_t view [64];  // architectural contents seen by the requester

// window line to byte address
// tag bits 11:8, set bits 5:4 (sets 0 to 3 only, so 16 lines share a set), word 3:2
function automatic cache_bus_pkg::addr_t addr_of(input lidx_t ln, input logic [1:0] w);
  cache_bus_pkg::addr_t a;
  a       = '0;
  a[11:8] = ln[5:2];
  a[5:4]  = ln[1:0];
  a[3:2]  = w;
  return a;
endfunction

function automatic lidx_t line_of(input cache_bus_pkg::addr_t a);
  return {a[11:8], a[5:4]};
endfunction

function automatic int rand_below(input int n);
  int r;
  r = $random(seed);
  return int'($unsigned(r) % n);
endfunction

function automatic cache_bus_pkg::word_t rand_word();
  return cache_bus_pkg::word_t'($random(seed));
endfunction

// random words mixed with their full byte address
function automatic void init_memory();
  for (int l = 0; l < 64; l++) begin
    for (int w = 0; w < 4; w++) begin
      mem[l][w*32 +: 32] = rand_word() ^ addr_of(lidx_t'(l), 2'(w));
    end
    view[l] = mem[l];  // nothing cached yet
  end
endfunction

function automatic void write_view(input cache_bus_pkg::addr_t a,
                                   input cache_bus_pkg::word_t d);
  view[line_of(a)][int'(a[3:2])*32 +: 32] = d;
endfunction

// flush drops dirty lines, so the view falls back to lower memory
function automatic void reload_view();
  for (int l = 0; l < 64; l++) view[l] = mem[l];
endfunction

// expected load data is the latest stored word, or memory if never stored
function automatic cache_bus_pkg::word_t expected_read(input cache_bus_pkg::addr_t a);
  return view[line_of(a)][int'(a[3:2])*32 +: 32];
endfunction

`endif

// ==== bench/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;

  localparam int NUM_WAYS   = 4;
  localparam int NUM_SETS   = 16;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 5;

  logic                     clk_in = 1'b0;
  logic                     rst_N_in;
  logic                     flush;
  logic                     req_valid, req_ready;
  cache_bus_pkg::cpu_req_t  req;
  logic                     resp_valid, resp_ready;
  cache_bus_pkg::cpu_resp_t resp;
  logic                     mem_req_valid, mem_req_ready;
  cache_bus_pkg::mem_req_t  mem_req;
  logic                     mem_resp_valid;
  cache_bus_pkg::mem_resp_t mem_resp;

  int   seed = 53;
  int   cmp_checks = 0;       // counted by the compare process
  int   cmp_errors = 0;
  int   seq_checks = 0;       // counted by the main sequence
  int   seq_errors = 0;
  int   last_checks = 0;      // totals at the end of the previous test
  int   last_errors = 0;
  int   wb_count = 0;         // lower writes seen
  logic expect_hit = 1'b0;    // next response must follow its request by 2 cycles
  logic bp_en = 1'b0;         // random ready back-pressure
  logic written [64];         // lines stored to at least once
  cache_bus_pkg::word_t exp_q [$];  // one entry per accepted request

  `include "cache_model.svh"

  cache_top #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) cache_top_i (.*);

  always #(CLK_PERIOD/2) clk_in = ~clk_in;

  // resp_ready and mem_req_ready
  initial begin : backpressure
    int r;
    resp_ready    = 1'b1;
    mem_req_ready = 1'b1;
    forever begin
      @(posedge clk_in);
      #1;
      r             = $random(seed);
      resp_ready    = bp_en ? r[0] : 1'b1;
      mem_req_ready = bp_en ? r[1] : 1'b1;
    end
  end

  // lower memory answers each line fetch after 0 to 5 idle cycles
  initial begin : responder
    lidx_t ln;
    int    lat;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    forever begin
      @(negedge clk_in);
      if (mem_req_valid && mem_req_ready && !mem_req.write) begin
        ln  = line_of(mem_req.addr);
        lat = rand_below(6);
        @(posedge clk_in);  // read transfer
        repeat (lat) @(posedge clk_in);
        #1;
        mem_resp.rdata = mem[ln];
        mem_resp_valid = 1'b1;  // one cycle only
        @(posedge clk_in);
        #1;
        mem_resp_valid = 1'b0;
      end
    end
  end

  // samples all handshakes half a cycle before the edge that takes them
  initial begin : compare
    cache_bus_pkg::word_t exp_word;
    lidx_t                ln;
    int                   cycle;
    int                   req_cycle;
    cycle     = 0;
    req_cycle = 0;
    init_memory();
    forever begin
      @(negedge clk_in);
      cycle++;
      if (resp_valid && resp_ready) begin
        cmp_checks++;
        assert (exp_q.size() > 0) else begin
          $display("response at cycle %0d with no request outstanding", cycle);
          cmp_errors++;
        end
        if (exp_q.size() > 0) begin
          exp_word = exp_q.pop_front();
          assert (resp.rdata == exp_word) else begin
            $display("CHECK FAILED resp.rdata expected %h actual %h", exp_word, resp.rdata);
            cmp_errors++;
          end
        end
        if (expect_hit) begin
          assert (cycle - req_cycle == 2) else begin
            $display("warm hit answered after %0d cycles instead of 2", cycle - req_cycle);
            cmp_errors++;
          end
        end
      end
      if (req_valid && req_ready) begin
        req_cycle = cycle;
        if (req.write) begin
          exp_q.push_back(32'h0);  // stores answer zero
          write_view(req.addr, req.wdata);
        end else begin
          exp_q.push_back(expected_read(req.addr));
        end
      end
      if (mem_req_valid && mem_req_ready && mem_req.write) begin
        ln = line_of(mem_req.addr);
        wb_count++;
        cmp_checks++;
        assert (mem_req.wdata == view[ln]) else begin
          $display("CHECK FAILED mem_req.wdata expected %h actual %h", view[ln], mem_req.wdata);
          cmp_errors++;
        end
        mem[ln] = mem_req.wdata;
      end
      if (flush) reload_view();  // only pulsed while idle
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("run did not finish within %0d cycles", NUM_TESTS * 2000);
    $display("Simulation failed");
    $finish;
  end

  function automatic cache_bus_pkg::addr_t rand_addr();
    return addr_of(lidx_t'(rand_below(64)), 2'(rand_below(4)));
  endfunction

  // one request, returns 1 ns after its response transfer
  task automatic send_req(input logic wr, input cache_bus_pkg::addr_t a,
                          input cache_bus_pkg::word_t d);
    req_valid = 1'b1;
    req       = '{write: wr, addr: a, wdata: d};
    do @(negedge clk_in); while (!req_ready);
    @(posedge clk_in);
    #1;
    req_valid = 1'b0;
    if (wr) written[line_of(a)] = 1'b1;
    do @(negedge clk_in); while (!(resp_valid && resp_ready));
    @(posedge clk_in);
    #1;
  endtask

  // counts the cycles where req_ready stays low after the flush is taken
  task automatic pulse_flush(output int low_cycles);
    flush = 1'b1;
    @(posedge clk_in);
    #1;
    flush      = 1'b0;
    low_cycles = 0;
    while (!req_ready && low_cycles < 4 * NUM_SETS) begin
      low_cycles++;
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    int c;
    int e;
    seq_checks++;
    assert (exp_q.size() == 0) else begin
      $display("%0d accepted requests got no response", exp_q.size());
      seq_errors++;
    end
    c = cmp_checks + seq_checks;
    e = cmp_errors + seq_errors;
    $display("test %0d %s: %0d checks, %0d errors", num, name, c - last_checks, e - last_errors);
    last_checks = c;
    last_errors = e;
  endtask

  initial begin : main
    cache_bus_pkg::addr_t a;
    cache_bus_pkg::addr_t addrs [$];
    lidx_t                ln;
    int                   n;
    rst_N_in  = 1'b0;
    flush     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int l = 0; l < 64; l++) written[l] = 1'b0;
    repeat (4) @(posedge clk_in);
    #1;
    rst_N_in = 1'b1;

    for (int i = 0; i < 4; i++) begin
      a = rand_addr();
      send_req(1'b1, a, rand_word());  // store misses and fills the line
      expect_hit = 1'b1;
      send_req(1'b0, a, 32'h0);
      expect_hit = 1'b0;
    end
    finish_test(1, "read after write");

    for (int i = 0; i < 8; i++) begin
      ln = lidx_t'(rand_below(64));
      while (written[ln]) ln = ln + 6'd1;  // skip lines already stored to
      send_req(1'b0, addr_of(ln, 2'(rand_below(4))), 32'h0);
    end
    finish_test(2, "cold reads");

    // eight lines through the four ways of set 2
    n = wb_count;
    for (int k = 0; k < 8; k++) send_req(1'b1, addr_of(lidx_t'(2 + 4 * k), 2'(k)), rand_word());
    for (int k = 7; k >= 0; k--) send_req(1'b0, addr_of(lidx_t'(2 + 4 * k), 2'(k)), 32'h0);
    seq_checks++;
    assert (wb_count > n) else begin
      $display("no write-back seen while overfilling set 2");
      seq_errors++;
    end
    finish_test(3, "evictions");

    bp_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      a = rand_addr();
      if (rand_below(2) == 1) send_req(1'b1, a, rand_word());
      else send_req(1'b0, a, 32'h0);
    end
    bp_en = 1'b0;
    repeat (2) @(posedge clk_in);  // readies settle high
    #1;
    finish_test(4, "random traffic with back-pressure");

    for (int i = 0; i < 6; i++) begin
      a = rand_addr();
      addrs.push_back(a);
      send_req(1'b1, a, rand_word());
    end
    pulse_flush(n);
    seq_checks++;
    assert (n == NUM_SETS) else begin
      $display("req_ready stayed low %0d cycles after flush, expected %0d", n, NUM_SETS);
      seq_errors++;
    end
    foreach (addrs[i]) send_req(1'b0, addrs[i], 32'h0);  // dirty words fall back to memory
    finish_test(5, "flush");

    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, cmp_checks + seq_checks,
             cmp_errors + seq_errors);
    if (cmp_errors + seq_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+bench
rtl/cache_bus_pkg.sv
rtl/cache_core_pkg.sv
rtl/plru_tree.sv
rtl/data_store.sv
rtl/tag_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
bench/cache_tb.sv

// ==== rtl/cache_bus_pkg.sv ====
package cache_bus_pkg;

  // fixed port widths
  localparam int ADDR_W     = 32;               // byte address
  localparam int WORD_W     = 32;               // requester data word
  localparam int LINE_BYTES = 16;               // four words per line
  localparam int LINE_W     = LINE_BYTES * 8;   // line in bits

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;

  // upper side request, held by the requester until req_ready
  typedef struct packed {
    logic  write;  // 1 = store word, 0 = load word
    addr_t addr;   // byte address, word aligned
    word_t wdata;  // store data, ignored on loads
  } cpu_req_t;

  // upper side response
  typedef struct packed {
    word_t rdata;  // load data, zero for a store
  } cpu_resp_t;

  // lower side request, one whole line per transfer
  typedef struct packed {
    logic  write;  // 1 = write-back of a victim, 0 = line fetch
    addr_t addr;   // line aligned
    line_t wdata;  // victim line on write-back
  } mem_req_t;

  // lower side response, one per line fetch
  typedef struct packed {
    line_t rdata;  // fill line, always clean
  } mem_resp_t;

endpackage

// ==== rtl/cache_core_pkg.sv ====
package cache_core_pkg;

  // address split: | tag (set bits included) | word select | byte |
  localparam int OFFSET_W   = 4;  // byte offset inside a 16 byte line
  localparam int WORD_SEL_W = 2;  // word inside the line
  localparam int TAG_W      = cache_bus_pkg::ADDR_W - OFFSET_W;

  // set bits stay inside the tag so the width is independent of NUM_SETS
  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    logic valid;
    logic dirty;  // line differs from lower memory
    tag_t tag;
  } tag_entry_t;

  // controller states
  typedef enum logic [3:0] {
    IDLE,       // waiting for a request or a flush
    LOOKUP,     // tag compare, hit service
    EVICT,      // write-back of a dirty victim
    FILL_REQ,   // line fetch request out
    FILL_WAIT,  // waiting for the fill line
    REFILL,     // write fill line and tag
    RESPOND,    // response held until resp_ready
    FLUSH       // invalidate one set per cycle
  } ctrl_state_t;

endpackage

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                                   clk_in,
  input  logic                                   rst_N_in,
  input  logic                                   flush,
  input  logic                                   req_valid,
  output logic                                   req_ready,
  input  cache_bus_pkg::cpu_req_t                req,
  output logic                                   resp_valid,
  input  logic                                   resp_ready,
  output cache_bus_pkg::cpu_resp_t               resp,
  output logic                                   mem_req_valid,
  input  logic                                   mem_req_ready,
  output cache_bus_pkg::mem_req_t                mem_req,
  input  logic                                   mem_resp_valid,
  input  cache_bus_pkg::mem_resp_t               mem_resp,
  input  logic                                   hit,
  input  logic [$clog2(NUM_WAYS)-1:0]            hit_way,
  input  cache_core_pkg::tag_entry_t             victim_entry,
  input  logic [$clog2(NUM_WAYS)-1:0]            victim_way,
  input  cache_bus_pkg::word_t                   rd_word,
  input  cache_bus_pkg::line_t                   rd_line,
  output logic [$clog2(NUM_SETS)-1:0]            lookup_set,
  output cache_core_pkg::tag_t                   lookup_tag,
  output logic [cache_core_pkg::WORD_SEL_W-1:0]  word_sel,
  output logic [$clog2(NUM_WAYS)-1:0]            way_sel,
  output logic                                   tag_mark_dirty,
  output logic                                   tag_install,
  output logic                                   tag_invalidate,
  output logic                                   data_write_word,
  output logic                                   data_write_line,
  output cache_bus_pkg::word_t                   wr_word,
  output cache_bus_pkg::line_t                   wr_line,
  output logic                                   plru_touch
);

  localparam int SET_W = $clog2(NUM_SETS);
  localparam int OFF_W = cache_core_pkg::OFFSET_W;

  cache_core_pkg::ctrl_state_t state_q, state_d;
  logic                        ready_en;   // low for the first cycle out of reset
  logic [SET_W-1:0]            flush_set;  // set being invalidated
  logic [$clog2(NUM_WAYS)-1:0] victim_q;   // way chosen on the miss
  cache_bus_pkg::cpu_req_t     req_q;      // accepted request
  cache_bus_pkg::cpu_resp_t    resp_q;
  cache_bus_pkg::mem_req_t     mem_req_q;
  cache_bus_pkg::mem_req_t     fill_req;   // line fetch for the held request
  cache_bus_pkg::line_t        fill_q;     // fill line waiting for REFILL

  // address fields of the held request, flush walks the sets instead
  assign lookup_tag = req_q.addr[cache_bus_pkg::ADDR_W-1:OFF_W];
  assign word_sel   = req_q.addr[OFF_W-1 -: cache_core_pkg::WORD_SEL_W];
  assign lookup_set = (state_q == cache_core_pkg::FLUSH) ? flush_set
                                                         : req_q.addr[OFF_W +: SET_W];
  assign wr_word = req_q.wdata;
  assign wr_line = fill_q;
  assign fill_req = '{write: 1'b0, addr: {lookup_tag, {OFF_W{1'b0}}}, wdata: '0};

  // handshakes, flush wins over a request in the same cycle
  assign req_ready     = (state_q == cache_core_pkg::IDLE) && ready_en && !flush;
  assign resp_valid    = (state_q == cache_core_pkg::RESPOND);
  assign resp          = resp_q;
  assign mem_req_valid = (state_q == cache_core_pkg::EVICT) ||
                         (state_q == cache_core_pkg::FILL_REQ);
  assign mem_req       = mem_req_q;

  always_comb begin
    state_d         = state_q;
    way_sel         = victim_q;  // miss path works on the saved victim
    tag_mark_dirty  = 1'b0;
    tag_install     = 1'b0;
    tag_invalidate  = 1'b0;
    data_write_word = 1'b0;
    data_write_line = 1'b0;
    plru_touch      = 1'b0;
    case (state_q)
      cache_core_pkg::IDLE: begin
        if (flush) state_d = cache_core_pkg::FLUSH;
        else if (req_valid && req_ready) state_d = cache_core_pkg::LOOKUP;
      end
      cache_core_pkg::LOOKUP: begin
        if (hit) begin
          way_sel         = hit_way;
          plru_touch      = 1'b1;         // hit way becomes most recent
          data_write_word = req_q.write;  // store lands in place
          tag_mark_dirty  = req_q.write;
          state_d         = cache_core_pkg::RESPOND;
        end else begin
          way_sel = victim_way;           // rd_line now holds the victim
          state_d = (victim_entry.valid && victim_entry.dirty) ? cache_core_pkg::EVICT
                                                               : cache_core_pkg::FILL_REQ;
        end
      end
      cache_core_pkg::EVICT:     if (mem_req_ready) state_d = cache_core_pkg::FILL_REQ;
      cache_core_pkg::FILL_REQ:  if (mem_req_ready) state_d = cache_core_pkg::FILL_WAIT;
      cache_core_pkg::FILL_WAIT: if (mem_resp_valid) state_d = cache_core_pkg::REFILL;
      cache_core_pkg::REFILL: begin
        data_write_line = 1'b1;
        tag_install     = 1'b1;
        state_d         = cache_core_pkg::LOOKUP;  // replays as a hit
      end
      cache_core_pkg::RESPOND:   if (resp_ready) state_d = cache_core_pkg::IDLE;
      cache_core_pkg::FLUSH: begin
        tag_invalidate = 1'b1;
        if (&flush_set) state_d = cache_core_pkg::IDLE;  // last set done
      end
      default: state_d = cache_core_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q   <= cache_core_pkg::IDLE;
      ready_en  <= 1'b0;
      flush_set <= '0;
    end else begin
      state_q  <= state_d;
      ready_en <= 1'b1;
      if (state_q == cache_core_pkg::FLUSH) flush_set <= flush_set + 1'b1;  // wraps to 0
    end
  end

  // request, response and line payloads
  always_ff @(posedge clk_in) begin
    if (req_valid && req_ready) req_q <= req;
    if (state_q == cache_core_pkg::LOOKUP) begin
      if (hit) begin
        resp_q.rdata <= req_q.write ? '0 : rd_word;
      end else begin
        victim_q <= victim_way;
        if (victim_entry.valid && victim_entry.dirty)
          mem_req_q <= '{write: 1'b1, addr: {victim_entry.tag, {OFF_W{1'b0}}}, wdata: rd_line};
        else
          mem_req_q <= fill_req;
      end
    end
    if (state_q == cache_core_pkg::EVICT && mem_req_ready) mem_req_q <= fill_req;
    if (state_q == cache_core_pkg::FILL_WAIT && mem_resp_valid) fill_q <= mem_resp.rdata;
  end

  // both outputs hold under back-pressure
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps

module cache_top #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     flush,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cache_bus_pkg::cpu_req_t  req,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output cache_bus_pkg::cpu_resp_t resp,
  output logic                     mem_req_valid,
  input  logic                     mem_req_ready,
  output cache_bus_pkg::mem_req_t  mem_req,
  input  logic                     mem_resp_valid,
  input  cache_bus_pkg::mem_resp_t mem_resp
);

  localparam int WAY_W = $clog2(NUM_WAYS);
  localparam int SET_W = $clog2(NUM_SETS);

  // lookup address from the controller
  logic [SET_W-1:0]                       lookup_set;
  cache_core_pkg::tag_t                   lookup_tag;
  logic [cache_core_pkg::WORD_SEL_W-1:0]  word_sel;
  logic [WAY_W-1:0]                       way_sel;

  // tag store
  logic                      hit;
  logic [WAY_W-1:0]          hit_way;
  cache_core_pkg::tag_entry_t victim_entry;
  logic                      tag_mark_dirty, tag_install, tag_invalidate;

  // data store
  logic                 data_write_word, data_write_line;
  cache_bus_pkg::word_t wr_word, rd_word;
  cache_bus_pkg::line_t wr_line, rd_line;

  // replacement
  logic             plru_touch;
  logic [WAY_W-1:0] victim_way;

  cache_ctrl #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) ctrl_i (.*);

  tag_store #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) tag_store_i (
    .clk_in, .rst_N_in, .lookup_set, .lookup_tag, .way_sel,
    .tag_mark_dirty, .tag_install, .tag_invalidate,
    .hit, .hit_way, .victim_entry, .victim_way
  );

  data_store #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) data_store_i (
    .clk_in, .lookup_set, .word_sel, .way_sel,
    .data_write_word, .data_write_line, .wr_word, .wr_line,
    .rd_word, .rd_line
  );

  plru_tree #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) plru_i (
    .clk_in, .rst_N_in, .lookup_set, .plru_touch, .way_sel, .victim_way
  );

endmodule

// ==== rtl/data_store.sv ====
`timescale 1ns/100ps

module data_store #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                                  clk_in,
  input  logic [$clog2(NUM_SETS)-1:0]           lookup_set,
  input  logic [cache_core_pkg::WORD_SEL_W-1:0] word_sel,
  input  logic [$clog2(NUM_WAYS)-1:0]           way_sel,
  input  logic                                  data_write_word,
  input  logic                                  data_write_line,
  input  cache_bus_pkg::word_t                  wr_word,
  input  cache_bus_pkg::line_t                  wr_line,
  output cache_bus_pkg::word_t                  rd_word,
  output cache_bus_pkg::line_t                  rd_line
);

  localparam int WORD_W = cache_bus_pkg::WORD_W;

  cache_bus_pkg::line_t lines [NUM_WAYS][NUM_SETS];  // no reset, tags say what is valid

  // combinational read of the addressed way and set
  assign rd_line = lines[way_sel][lookup_set];
  assign rd_word = rd_line[word_sel*WORD_W +: WORD_W];

  always_ff @(posedge clk_in) begin
    if (data_write_line)
      lines[way_sel][lookup_set] <= wr_line;  // refill from memory
    else if (data_write_word)
      lines[way_sel][lookup_set][word_sel*WORD_W +: WORD_W] <= wr_word;  // store hit
  end

endmodule

// ==== rtl/plru_tree.sv ====
`timescale 1ns/100ps

module plru_tree #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic [$clog2(NUM_SETS)-1:0] lookup_set,
  input  logic                        plru_touch,
  input  logic [$clog2(NUM_WAYS)-1:0] way_sel,
  output logic [$clog2(NUM_WAYS)-1:0] victim_way
);

  localparam int LEVELS = $clog2(NUM_WAYS);

  // heap order: node n has children 2n+1 (low half) and 2n+2 (high half)
  logic [NUM_WAYS-2:0] tree [NUM_SETS];
  logic [NUM_WAYS-2:0] touched;  // tree of the set after a touch

  always_comb begin
    int   node;
    logic dir;
    // walk from the root along the bits to find the victim
    node       = 0;
    victim_way = '0;
    for (int l = 0; l < LEVELS; l++) begin
      dir                      = tree[lookup_set][node];  // 1 = high half is older
      victim_way[LEVELS-1-l]   = dir;
      node                     = 2 * node + 1 + int'(dir);
    end
    // touch points every node on the path away from way_sel
    node    = 0;
    touched = tree[lookup_set];
    for (int l = 0; l < LEVELS; l++) begin
      dir           = way_sel[LEVELS-1-l];
      touched[node] = ~dir;
      node          = 2 * node + 1 + int'(dir);
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) tree[s] <= '0;  // all point at way 0
    end else if (plru_touch) begin
      tree[lookup_set] <= touched;
    end
  end

  // a way just touched is never the next victim of its set
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    plru_touch |=> (lookup_set != $past(lookup_set)) || (victim_way != $past(way_sel)));

endmodule

// ==== rtl/tag_store.sv ====
`timescale 1ns/100ps

module tag_store #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic [$clog2(NUM_SETS)-1:0] lookup_set,
  input  cache_core_pkg::tag_t        lookup_tag,
  input  logic [$clog2(NUM_WAYS)-1:0] way_sel,
  input  logic                        tag_mark_dirty,
  input  logic                        tag_install,
  input  logic                        tag_invalidate,
  output logic                        hit,
  output logic [$clog2(NUM_WAYS)-1:0] hit_way,
  output cache_core_pkg::tag_entry_t  victim_entry,
  input  logic [$clog2(NUM_WAYS)-1:0] victim_way
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  cache_core_pkg::tag_entry_t entries [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0]        match;  // one bit per way

  // compare all ways of the addressed set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = entries[w][lookup_set].valid && (entries[w][lookup_set].tag == lookup_tag);
      if (match[w]) hit_way = WAY_W'(w);
    end
  end

  assign hit          = |match;
  assign victim_entry = entries[victim_way][lookup_set];  // feeds the write-back decision

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          entries[w][s].valid <= 1'b0;
          entries[w][s].dirty <= 1'b0;
        end
      end
    end else if (tag_invalidate) begin
      // flush drops dirty lines without write-back
      for (int w = 0; w < NUM_WAYS; w++) begin
        entries[w][lookup_set].valid <= 1'b0;
        entries[w][lookup_set].dirty <= 1'b0;
      end
    end else if (tag_install) begin
      entries[way_sel][lookup_set] <= '{valid: 1'b1, dirty: 1'b0, tag: lookup_tag};
    end else if (tag_mark_dirty) begin
      entries[way_sel][lookup_set].dirty <= 1'b1;  // store hit
    end
  end

  // install only follows a miss, so a tag never lives in two ways of a set
  assert property (@(posedge clk_in) disable iff (!rst_N_in) $onehot0(match));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f flist.f --top-module cache_tb -o cache_sim \
  && ./obj_dir/cache_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
